/* Makefile */
# Verilator build and run of the board harness testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_board_sim -f project.f
	./obj_dir/Vtb_board_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG) || \
	   ! grep -q "Test passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* hdl/board_pin_pkg.sv */
/*
 * Board pin definitions for the simulation harness.
 * Pin counts, pin indices, pin-vector types and the I2C bus numbering.
 */
package board_pin_pkg;

  // Output pins driven by the system.
  localparam int unsigned NumOutPins = 10;
  typedef logic [NumOutPins-1:0] out_pins_t;

  localparam int unsigned OUT_PIN_SER0_TX    = 0;
  localparam int unsigned OUT_PIN_SER1_TX    = 1;
  localparam int unsigned OUT_PIN_APPSPI_D0  = 2;
  localparam int unsigned OUT_PIN_APPSPI_CLK = 3;
  localparam int unsigned OUT_PIN_APPSPI_CS  = 4;
  localparam int unsigned OUT_PIN_LCD_COPI   = 5;
  localparam int unsigned OUT_PIN_LCD_CLK    = 6;
  localparam int unsigned OUT_PIN_LCD_CS     = 7;
  localparam int unsigned OUT_PIN_MB4        = 8;  // mikroBUS COPI.
  localparam int unsigned OUT_PIN_MB7        = 9;  // mikroBUS TX.

  // Input pins read by the system.
  localparam int unsigned NumInPins = 5;
  typedef logic [NumInPins-1:0] in_pins_t;

  localparam int unsigned IN_PIN_SER0_RX   = 0;
  localparam int unsigned IN_PIN_SER1_RX   = 1;
  localparam int unsigned IN_PIN_APPSPI_D1 = 2;
  localparam int unsigned IN_PIN_MB3       = 3;  // mikroBUS CIPO.
  localparam int unsigned IN_PIN_MB8       = 4;  // mikroBUS RX.

  // Bidirectional pins.
  localparam int unsigned NumInoutPins = 14;
  typedef logic [NumInoutPins-1:0] inout_pins_t;

  localparam int unsigned INOUT_PIN_SCL0       = 0;
  localparam int unsigned INOUT_PIN_SDA0       = 1;
  localparam int unsigned INOUT_PIN_SCL1       = 2;
  localparam int unsigned INOUT_PIN_SDA1       = 3;
  localparam int unsigned INOUT_PIN_RPH_G0     = 4;
  localparam int unsigned INOUT_PIN_RPH_G1     = 5;
  localparam int unsigned INOUT_PIN_RPH_G2_SDA = 6;
  localparam int unsigned INOUT_PIN_RPH_G3_SCL = 7;
  localparam int unsigned INOUT_PIN_MB5        = 8;
  localparam int unsigned INOUT_PIN_MB6        = 9;
  localparam int unsigned INOUT_PIN_AH_TMPIO0  = 10;
  localparam int unsigned INOUT_PIN_AH_TMPIO1  = 11;
  localparam int unsigned INOUT_PIN_AH_TMPIO8  = 12;
  localparam int unsigned INOUT_PIN_AH_TMPIO9  = 13;

  // Modelled I2C buses, one bit each in a line vector.
  localparam int unsigned NumI2cBuses = 3;
  typedef logic [NumI2cBuses-1:0] i2c_lines_t;

  localparam int unsigned I2C_BUS_RPI0   = 0;  // HAT ID EEPROM bus.
  localparam int unsigned I2C_BUS_RPI1   = 1;  // HAT secondary bus.
  localparam int unsigned I2C_BUS_QWIIC1 = 2;

endpackage

/* hdl/board_sim_top.sv */
/*
 * Board simulation harness top level.
 * Connects the system pin vectors to the device ports through the I2C
 * fabric, the pin router and the CHERI error monitor.
 */
`timescale 1ns/1ps

module board_sim_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // System side.
  input  board_pin_pkg::out_pins_t   out_to_pins_i,
  input  board_pin_pkg::inout_pins_t inout_to_pins_i,
  input  board_pin_pkg::inout_pins_t inout_to_pins_en_i,
  input  cheri_err_pkg::cheri_err_t  cheri_err_i,
  output board_pin_pkg::in_pins_t    in_from_pins_o,
  output board_pin_pkg::inout_pins_t inout_from_pins_o,
  // Device side.
  input  board_pin_pkg::i2c_lines_t  i2c_scl_dev_i,
  input  board_pin_pkg::i2c_lines_t  i2c_sda_dev_i,
  output board_pin_pkg::i2c_lines_t  i2c_scl_drv_o,
  output board_pin_pkg::i2c_lines_t  i2c_sda_drv_o,
  input  logic                       uart_rx_i,
  input  logic                       flash_cipo_i,
  output logic                       uart_tx_o,
  output logic                       flash_sck_o,
  output logic                       flash_cs_o,
  output logic                       flash_copi_o,
  output logic                       lcd_sck_o,
  output logic                       lcd_cs_o,
  output logic                       lcd_copi_o,
  // Error tracking.
  output cheri_err_pkg::cheri_err_t  cheri_errored_o,
  output cheri_err_pkg::cheri_err_t  cheri_new_o
);
  import board_pin_pkg::*;

  // Resolved I2C levels with pull-ups on the unmodelled pins.
  inout_pins_t i2c_from_pins;

  i2c_bus_fabric u_i2c_bus_fabric (
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .i2c_scl_dev_i      (i2c_scl_dev_i),
    .i2c_sda_dev_i      (i2c_sda_dev_i),
    .i2c_scl_drv_o      (i2c_scl_drv_o),
    .i2c_sda_drv_o      (i2c_sda_drv_o),
    .i2c_from_pins_o    (i2c_from_pins)
  );

  pin_route u_pin_route (
    .clk_i,
    .rst_ni,
    .out_to_pins_i,
    .inout_to_pins_i,
    .i2c_from_pins_i (i2c_from_pins),
    .uart_rx_i,
    .flash_cipo_i,
    .in_from_pins_o,
    .inout_from_pins_o,
    .uart_tx_o,
    .flash_sck_o,
    .flash_cs_o,
    .flash_copi_o,
    .lcd_sck_o,
    .lcd_cs_o,
    .lcd_copi_o
  );

  cheri_err_monitor u_cheri_err_monitor (
    .clk_i,
    .rst_ni,
    .cheri_err_i,
    .cheri_errored_o,
    .cheri_new_o
  );

endmodule

/* hdl/cheri_err_monitor.sv */
/*
 * CHERI error monitor.
 * Latches each error cause on first occurrence and pulses the new ones.
 */
`timescale 1ns/1ps

module cheri_err_monitor (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  cheri_err_pkg::cheri_err_t cheri_err_i,
  output cheri_err_pkg::cheri_err_t cheri_errored_o,
  output cheri_err_pkg::cheri_err_t cheri_new_o
);
  import cheri_err_pkg::*;

  // Sticky record of every cause seen so far.
  cheri_err_t errored_q;
  // Causes first seen at the last edge.
  cheri_err_t new_q;
  cheri_err_t first_seen;

  // The error lines drive board LEDs and are modulated.
  // Only a cause not yet recorded counts as new.
  assign first_seen = cheri_err_i & ~errored_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      errored_q <= '0;
      new_q     <= '0;
    end else begin
      errored_q <= errored_q | cheri_err_i;
      // The record masks the pulse after one cycle.
      new_q     <= first_seen;
    end
  end

  assign cheri_errored_o = errored_q;
  assign cheri_new_o     = new_q;

endmodule

/* hdl/cheri_err_pkg.sv */
/*
 * CHERI error cause definitions.
 * Cause count, bit index of each cause and the error-vector type.
 */
package cheri_err_pkg;

  // Number of distinct CHERI error causes.
  localparam int unsigned CheriErrWidth = 9;
  typedef logic [CheriErrWidth-1:0] cheri_err_t;

  // Capability checks.
  localparam int unsigned CHERI_ERR_BOUNDS = 0;
  localparam int unsigned CHERI_ERR_TAG    = 1;
  localparam int unsigned CHERI_ERR_SEAL   = 2;

  // Permission checks.
  localparam int unsigned CHERI_ERR_PERM_EX      = 3;
  localparam int unsigned CHERI_ERR_PERM_LD      = 4;
  localparam int unsigned CHERI_ERR_PERM_ST      = 5;
  localparam int unsigned CHERI_ERR_PERM_ST_CAP  = 6;
  localparam int unsigned CHERI_ERR_PERM_ST_LCAP = 7;
  // Access to system registers.
  localparam int unsigned CHERI_ERR_PERM_SYS     = 8;

endpackage

/* hdl/i2c_bus_fabric.sv */
/*
 * I2C bus fabric.
 * Resolves the three modelled open-drain buses as a wired-AND of the
 * controller drive and the device pull-down; all other pins read pulled up.
 */
`timescale 1ns/1ps

module i2c_bus_fabric (
  input  board_pin_pkg::inout_pins_t inout_to_pins_i,
  input  board_pin_pkg::inout_pins_t inout_to_pins_en_i,
  input  board_pin_pkg::i2c_lines_t  i2c_scl_dev_i,
  input  board_pin_pkg::i2c_lines_t  i2c_sda_dev_i,
  output board_pin_pkg::i2c_lines_t  i2c_scl_drv_o,
  output board_pin_pkg::i2c_lines_t  i2c_sda_drv_o,
  output board_pin_pkg::inout_pins_t i2c_from_pins_o
);
  import board_pin_pkg::*;

  // Controller pin value and enable, gathered per bus.
  i2c_lines_t scl_val;
  i2c_lines_t scl_en;
  i2c_lines_t sda_val;
  i2c_lines_t sda_en;

  // Resolved line level as seen on the wire.
  i2c_lines_t scl_bus;
  i2c_lines_t sda_bus;

  // HAT ID bus.
  assign scl_val[I2C_BUS_RPI0] = inout_to_pins_i[INOUT_PIN_RPH_G1];
  assign scl_en[I2C_BUS_RPI0]  = inout_to_pins_en_i[INOUT_PIN_RPH_G1];
  assign sda_val[I2C_BUS_RPI0] = inout_to_pins_i[INOUT_PIN_RPH_G0];
  assign sda_en[I2C_BUS_RPI0]  = inout_to_pins_en_i[INOUT_PIN_RPH_G0];

  // HAT secondary bus shared with GPIO2/3.
  assign scl_val[I2C_BUS_RPI1] = inout_to_pins_i[INOUT_PIN_RPH_G3_SCL];
  assign scl_en[I2C_BUS_RPI1]  = inout_to_pins_en_i[INOUT_PIN_RPH_G3_SCL];
  assign sda_val[I2C_BUS_RPI1] = inout_to_pins_i[INOUT_PIN_RPH_G2_SDA];
  assign sda_en[I2C_BUS_RPI1]  = inout_to_pins_en_i[INOUT_PIN_RPH_G2_SDA];

  // QWIIC1 connector.
  assign scl_val[I2C_BUS_QWIIC1] = inout_to_pins_i[INOUT_PIN_SCL1];
  assign scl_en[I2C_BUS_QWIIC1]  = inout_to_pins_en_i[INOUT_PIN_SCL1];
  assign sda_val[I2C_BUS_QWIIC1] = inout_to_pins_i[INOUT_PIN_SDA1];
  assign sda_en[I2C_BUS_QWIIC1]  = inout_to_pins_en_i[INOUT_PIN_SDA1];

  // A released line floats high through the pull-up.
  assign i2c_scl_drv_o = (scl_val & scl_en) | ~scl_en;
  assign i2c_sda_drv_o = (sda_val & sda_en) | ~sda_en;

  // Wired-AND with the device.
  // The controller must see its own traffic too, or it reports contention.
  assign scl_bus = i2c_scl_drv_o & i2c_scl_dev_i;
  assign sda_bus = i2c_sda_drv_o & i2c_sda_dev_i;

  always_comb begin
    // No model on QWIIC0, mikroBUS or the other pins; PCB pull-ups only.
    i2c_from_pins_o = '1;
    i2c_from_pins_o[INOUT_PIN_RPH_G1]     = scl_bus[I2C_BUS_RPI0];
    i2c_from_pins_o[INOUT_PIN_RPH_G0]     = sda_bus[I2C_BUS_RPI0];
    i2c_from_pins_o[INOUT_PIN_RPH_G3_SCL] = scl_bus[I2C_BUS_RPI1];
    i2c_from_pins_o[INOUT_PIN_RPH_G2_SDA] = sda_bus[I2C_BUS_RPI1];
    i2c_from_pins_o[INOUT_PIN_SCL1]       = scl_bus[I2C_BUS_QWIIC1];
    i2c_from_pins_o[INOUT_PIN_SDA1]       = sda_bus[I2C_BUS_QWIIC1];
  end

endmodule

/* hdl/pin_route.sv */
/*
 * Pin router.
 * Maps the pin vectors to the UART, flash and LCD ports, ties the fixed
 * inputs and retimes the four loopback pins through one register stage.
 */
`timescale 1ns/1ps

module pin_route (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  board_pin_pkg::out_pins_t   out_to_pins_i,
  input  board_pin_pkg::inout_pins_t inout_to_pins_i,
  input  board_pin_pkg::inout_pins_t i2c_from_pins_i,
  input  logic                       uart_rx_i,
  input  logic                       flash_cipo_i,
  output board_pin_pkg::in_pins_t    in_from_pins_o,
  output board_pin_pkg::inout_pins_t inout_from_pins_o,
  output logic                       uart_tx_o,
  output logic                       flash_sck_o,
  output logic                       flash_cs_o,
  output logic                       flash_copi_o,
  output logic                       lcd_sck_o,
  output logic                       lcd_cs_o,
  output logic                       lcd_copi_o
);
  import board_pin_pkg::*;

  // Bit 0 MB4, bit 1 MB7, bit 2 TMPIO1, bit 3 TMPIO8.
  logic [3:0] loopback_q;

  // Peripheral outputs straight from the pins.
  assign uart_tx_o    = out_to_pins_i[OUT_PIN_SER0_TX];
  assign flash_sck_o  = out_to_pins_i[OUT_PIN_APPSPI_CLK];
  assign flash_cs_o   = out_to_pins_i[OUT_PIN_APPSPI_CS];
  assign flash_copi_o = out_to_pins_i[OUT_PIN_APPSPI_D0];
  assign lcd_sck_o    = out_to_pins_i[OUT_PIN_LCD_CLK];
  assign lcd_cs_o     = out_to_pins_i[OUT_PIN_LCD_CS];
  assign lcd_copi_o   = out_to_pins_i[OUT_PIN_LCD_COPI];

  // One register stage breaks the net-level loop from outputs back to inputs.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= '0;
    end else begin
      loopback_q <= {inout_to_pins_i[INOUT_PIN_AH_TMPIO8],
                     inout_to_pins_i[INOUT_PIN_AH_TMPIO1],
                     out_to_pins_i[OUT_PIN_MB7],
                     out_to_pins_i[OUT_PIN_MB4]};
    end
  end

  always_comb begin
    in_from_pins_o = '0;
    in_from_pins_o[IN_PIN_SER0_RX]   = uart_rx_i;
    // Auxiliary UART idles high with nothing attached.
    in_from_pins_o[IN_PIN_SER1_RX]   = 1'b1;
    in_from_pins_o[IN_PIN_APPSPI_D1] = flash_cipo_i;
    in_from_pins_o[IN_PIN_MB3]       = loopback_q[0];  // SPI loopback.
    in_from_pins_o[IN_PIN_MB8]       = loopback_q[1];  // UART loopback.
  end

  always_comb begin
    // I2C resolution and pull-ups with the Arduino loopback laid over.
    inout_from_pins_o = i2c_from_pins_i;
    inout_from_pins_o[INOUT_PIN_AH_TMPIO0] = loopback_q[2];
    inout_from_pins_o[INOUT_PIN_AH_TMPIO9] = loopback_q[3];
  end

endmodule

/* project.f */
hdl/board_pin_pkg.sv
hdl/cheri_err_pkg.sv
hdl/i2c_bus_fabric.sv
hdl/pin_route.sv
hdl/cheri_err_monitor.sv
hdl/board_sim_top.sv
tests/board_sim_asserts.sv
tests/tb_board_sim.sv

/* tests/board_sim_asserts.sv */
/*
 * Concurrent assertions for the harness.
 * Sticky CHERI record, new-cause subset and one-cycle loopback timing.
 */
`timescale 1ns/1ps

module board_sim_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input board_pin_pkg::out_pins_t   out_to_pins_i,
  input board_pin_pkg::inout_pins_t inout_to_pins_i,
  input board_pin_pkg::in_pins_t    in_from_pins_o,
  input board_pin_pkg::inout_pins_t inout_from_pins_o,
  input cheri_err_pkg::cheri_err_t  cheri_errored_o,
  input cheri_err_pkg::cheri_err_t  cheri_new_o
);
  import board_pin_pkg::*;

  // Recorded causes are never dropped.
  sticky_errored: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(cheri_errored_o) & ~cheri_errored_o) == '0)
    else $error("CHERI error record lost a cause");

  // A new cause is always also recorded.
  new_in_record: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cheri_new_o & ~cheri_errored_o) == '0)
    else $error("CHERI new-cause pulse outside the record");

  // Loopback pins follow their source by one clock once out of reset.
  loopback_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |->
      (in_from_pins_o[IN_PIN_MB3] == $past(out_to_pins_i[OUT_PIN_MB4])) &&
      (in_from_pins_o[IN_PIN_MB8] == $past(out_to_pins_i[OUT_PIN_MB7])) &&
      (inout_from_pins_o[INOUT_PIN_AH_TMPIO0] == $past(inout_to_pins_i[INOUT_PIN_AH_TMPIO1])) &&
      (inout_from_pins_o[INOUT_PIN_AH_TMPIO9] == $past(inout_to_pins_i[INOUT_PIN_AH_TMPIO8])))
    else $error("Loopback pin did not follow its source by one cycle");

endmodule

bind board_sim_top board_sim_asserts u_board_sim_asserts (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .out_to_pins_i     (out_to_pins_i),
  .inout_to_pins_i   (inout_to_pins_i),
  .in_from_pins_o    (in_from_pins_o),
  .inout_from_pins_o (inout_from_pins_o),
  .cheri_errored_o   (cheri_errored_o),
  .cheri_new_o       (cheri_new_o)
);

/* tests/tb_board_sim.sv */
/*
 * Testbench for the board simulation harness.
 * Drives random pin, device and error traffic and checks every output
 * against reference models of the routing, I2C and CHERI latch rules.
 */
`timescale 1ns/1ps

module tb_board_sim;
  import board_pin_pkg::*;
  import cheri_err_pkg::*;

  localparam int NumCycles     = 2000;
  // Random cycles plus reset and drain, with some margin.
  localparam int TimeoutCycles = NumCycles + 100;

  logic        clk_i;
  logic        rst_ni;
  out_pins_t   out_to_pins_i;
  inout_pins_t inout_to_pins_i;
  inout_pins_t inout_to_pins_en_i;
  cheri_err_t  cheri_err_i;
  in_pins_t    in_from_pins_o;
  inout_pins_t inout_from_pins_o;
  i2c_lines_t  i2c_scl_dev_i;
  i2c_lines_t  i2c_sda_dev_i;
  i2c_lines_t  i2c_scl_drv_o;
  i2c_lines_t  i2c_sda_drv_o;
  logic        uart_rx_i;
  logic        flash_cipo_i;
  logic        uart_tx_o;
  logic        flash_sck_o;
  logic        flash_cs_o;
  logic        flash_copi_o;
  logic        lcd_sck_o;
  logic        lcd_cs_o;
  logic        lcd_copi_o;
  cheri_err_t  cheri_errored_o;
  cheri_err_t  cheri_new_o;

  logic [31:0] lcg_state = 32'heb004360;
  int          cycle_count = 0;

  // Expected state with the loop bits running MB4, MB7, TMPIO1 and TMPIO8 from bit 0 up.
  logic [3:0]  loop_model;
  cheri_err_t  errored_model;
  cheri_err_t  new_model;

  board_sim_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // A released line is pulled high.
  function automatic logic drive_level(logic val, logic en);
    return en ? val : 1'b1;
  endfunction

  function automatic i2c_lines_t bus_drive(inout_pins_t pins, inout_pins_t en, bit want_sda);
    i2c_lines_t res;
    if (want_sda) begin
      res[I2C_BUS_RPI0]   = drive_level(pins[INOUT_PIN_RPH_G0], en[INOUT_PIN_RPH_G0]);
      res[I2C_BUS_RPI1]   = drive_level(pins[INOUT_PIN_RPH_G2_SDA], en[INOUT_PIN_RPH_G2_SDA]);
      res[I2C_BUS_QWIIC1] = drive_level(pins[INOUT_PIN_SDA1], en[INOUT_PIN_SDA1]);
    end else begin
      res[I2C_BUS_RPI0]   = drive_level(pins[INOUT_PIN_RPH_G1], en[INOUT_PIN_RPH_G1]);
      res[I2C_BUS_RPI1]   = drive_level(pins[INOUT_PIN_RPH_G3_SCL], en[INOUT_PIN_RPH_G3_SCL]);
      res[I2C_BUS_QWIIC1] = drive_level(pins[INOUT_PIN_SCL1], en[INOUT_PIN_SCL1]);
    end
    return res;
  endfunction

  // Controller view is the wired-AND on the buses with pull-ups and loopback elsewhere.
  function automatic inout_pins_t expect_inout(inout_pins_t pins, inout_pins_t en,
                                               i2c_lines_t scl_dev, i2c_lines_t sda_dev,
                                               logic [3:0] loop);
    inout_pins_t res;
    i2c_lines_t  scl;
    i2c_lines_t  sda;
    scl = bus_drive(pins, en, 1'b0) & scl_dev;
    sda = bus_drive(pins, en, 1'b1) & sda_dev;
    res = '1;
    res[INOUT_PIN_RPH_G1]     = scl[I2C_BUS_RPI0];
    res[INOUT_PIN_RPH_G0]     = sda[I2C_BUS_RPI0];
    res[INOUT_PIN_RPH_G3_SCL] = scl[I2C_BUS_RPI1];
    res[INOUT_PIN_RPH_G2_SDA] = sda[I2C_BUS_RPI1];
    res[INOUT_PIN_SCL1]       = scl[I2C_BUS_QWIIC1];
    res[INOUT_PIN_SDA1]       = sda[I2C_BUS_QWIIC1];
    res[INOUT_PIN_AH_TMPIO0]  = loop[2];
    res[INOUT_PIN_AH_TMPIO9]  = loop[3];
    return res;
  endfunction

  function automatic in_pins_t expect_in(logic uart_rx, logic flash_cipo, logic [3:0] loop);
    in_pins_t res;
    res = '0;
    res[IN_PIN_SER0_RX]   = uart_rx;
    res[IN_PIN_SER1_RX]   = 1'b1;
    res[IN_PIN_APPSPI_D1] = flash_cipo;
    res[IN_PIN_MB3]       = loop[0];
    res[IN_PIN_MB8]       = loop[1];
    return res;
  endfunction

  // Printable name of each CHERI error cause.
  function automatic string cause_name(int unsigned idx);
    case (idx)
      CHERI_ERR_BOUNDS:       return "bounds";
      CHERI_ERR_TAG:          return "tag";
      CHERI_ERR_SEAL:         return "seal";
      CHERI_ERR_PERM_EX:      return "perm_ex";
      CHERI_ERR_PERM_LD:      return "perm_ld";
      CHERI_ERR_PERM_ST:      return "perm_st";
      CHERI_ERR_PERM_ST_CAP:  return "perm_st_cap";
      CHERI_ERR_PERM_ST_LCAP: return "perm_st_lcap";
      CHERI_ERR_PERM_SYS:     return "perm_sys";
      default:                return "unknown";
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    inout_pins_t exp_inout;
    exp_inout = expect_inout(inout_to_pins_i, inout_to_pins_en_i, i2c_scl_dev_i,
                             i2c_sda_dev_i, loop_model);
    check("uart_tx", 32'(out_to_pins_i[OUT_PIN_SER0_TX]), 32'(uart_tx_o));
    check("flash_sck", 32'(out_to_pins_i[OUT_PIN_APPSPI_CLK]), 32'(flash_sck_o));
    check("flash_cs", 32'(out_to_pins_i[OUT_PIN_APPSPI_CS]), 32'(flash_cs_o));
    check("flash_copi", 32'(out_to_pins_i[OUT_PIN_APPSPI_D0]), 32'(flash_copi_o));
    check("lcd_sck", 32'(out_to_pins_i[OUT_PIN_LCD_CLK]), 32'(lcd_sck_o));
    check("lcd_cs", 32'(out_to_pins_i[OUT_PIN_LCD_CS]), 32'(lcd_cs_o));
    check("lcd_copi", 32'(out_to_pins_i[OUT_PIN_LCD_COPI]), 32'(lcd_copi_o));
    check("i2c_scl_drv", 32'(bus_drive(inout_to_pins_i, inout_to_pins_en_i, 1'b0)),
          32'(i2c_scl_drv_o));
    check("i2c_sda_drv", 32'(bus_drive(inout_to_pins_i, inout_to_pins_en_i, 1'b1)),
          32'(i2c_sda_drv_o));
    check("inout_from_pins", 32'(exp_inout), 32'(inout_from_pins_o));
    check("in_from_pins", 32'(expect_in(uart_rx_i, flash_cipo_i, loop_model)),
          32'(in_from_pins_o));
    // One check per cause so a report names the cause that went wrong.
    for (int i = 0; i < CheriErrWidth; i++) begin
      check({"cheri_errored.", cause_name(i)}, 32'(errored_model[i]),
            32'(cheri_errored_o[i]));
      check({"cheri_new.", cause_name(i)}, 32'(new_model[i]), 32'(cheri_new_o[i]));
    end
  endtask

  task automatic drive_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    r0 = lcg_next();
    r1 = lcg_next();
    r2 = lcg_next();
    r3 = lcg_next();
    r4 = lcg_next();
    r5 = lcg_next();
    out_to_pins_i      <= r0[25:16];
    inout_to_pins_i    <= r1[29:16];
    inout_to_pins_en_i <= r2[29:16];
    // Devices release the lines more often than they pull.
    i2c_scl_dev_i      <= r3[18:16] | r3[26:24];
    i2c_sda_dev_i      <= r3[21:19] | r3[29:27];
    uart_rx_i          <= r3[22];
    flash_cipo_i       <= r3[23];
    // Two draws ANDed keep the error lines sparse.
    cheri_err_i        <= r4[24:16] & r5[24:16];
  endtask

  // Stimulus and end of run.
  initial begin
    rst_ni             <= 1'b0;
    out_to_pins_i      <= '0;
    inout_to_pins_i    <= '0;
    inout_to_pins_en_i <= '0;
    i2c_scl_dev_i      <= '1;
    i2c_sda_dev_i      <= '1;
    uart_rx_i          <= 1'b1;
    flash_cipo_i       <= 1'b0;
    cheri_err_i        <= '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NumCycles; i++) begin
      @(posedge clk_i);
      drive_random();
    end
    // Let the last inputs pass through the registered paths.
    repeat (2) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

  // Compare at the falling edge, then step the model across the next rising edge.
  initial begin
    loop_model    = '0;
    errored_model = '0;
    new_model     = '0;
    forever begin
      @(negedge clk_i);
      compare_outputs();
      if (!rst_ni) begin
        loop_model    = '0;
        errored_model = '0;
        new_model     = '0;
      end else begin
        new_model     = cheri_err_i & ~errored_model;
        errored_model = errored_model | cheri_err_i;
        loop_model    = {inout_to_pins_i[INOUT_PIN_AH_TMPIO8],
                         inout_to_pins_i[INOUT_PIN_AH_TMPIO1],
                         out_to_pins_i[OUT_PIN_MB7],
                         out_to_pins_i[OUT_PIN_MB4]};
      end
    end
  end

  initial begin
    wait (cycle_count >= TimeoutCycles);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Test failed");
    $fatal(1);
  end

endmodule
